// File: sim.f
hdl/core_cfg_pkg.sv
hdl/uop_pkg.sv
hdl/alu.sv
hdl/lsu.sv
hdl/data_scratchpad.sv
hdl/cdb_arbiter.sv
hdl/phys_regfile.sv
hdl/exec_cluster.sv
tests/exec_cluster_assert.sv
tests/exec_cluster_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execution cluster testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module exec_cluster_tb -f sim.f -o sim_exec_cluster \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_exec_cluster > sim.log 2>&1
cat sim.log
grep -q "^Testbench passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tests/exec_cluster_tb.sv
`timescale 1ns/1ns

module exec_cluster_tb import core_cfg_pkg::*, uop_pkg::*; ();

    logic                             clk;
    logic                             rst_n;
    logic                             alu0_valid;
    logic                             alu0_ready;
    uop_word_u                        alu0_op;
    logic [PTAG_W-1:0]                alu0_dst_tag;
    logic [XLEN-1:0]                  alu0_src1;
    logic [XLEN-1:0]                  alu0_src2;
    logic                             alu1_valid;
    logic                             alu1_ready;
    uop_word_u                        alu1_op;
    logic [PTAG_W-1:0]                alu1_dst_tag;
    logic [XLEN-1:0]                  alu1_src1;
    logic [XLEN-1:0]                  alu1_src2;
    logic                             lsu_valid;
    logic                             lsu_ready;
    uop_word_u                        lsu_op;
    logic [PTAG_W-1:0]                lsu_dst_tag;
    logic [XLEN-1:0]                  lsu_base;
    logic [XLEN-1:0]                  lsu_store_data;
    logic [CDB_LANES-1:0]             cdb_valid;
    logic [CDB_LANES-1:0][PTAG_W-1:0] cdb_tag;
    logic [CDB_LANES-1:0][XLEN-1:0]   cdb_value;
    logic [PTAG_W-1:0]                rd_tag;
    logic [XLEN-1:0]                  rd_data;

    // Scoreboard, indexed by tag
    int              seen_cnt  [NUM_PHYS];
    int              start_cnt [NUM_PHYS];
    int              seen_cyc  [NUM_PHYS];
    logic [XLEN-1:0] seen_val  [NUM_PHYS];
    logic [XLEN-1:0] exp_val   [NUM_PHYS];
    logic [XLEN-1:0] mem_model [DMEM_WORDS];
    logic [9:0]      written_q [$];
    int              cyc_cnt = 0;
    int              errors;
    int              checks;

    exec_cluster i_exec_cluster (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
    end

    // CDB monitor, samples mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            for (int l = 0; l < CDB_LANES; l++) begin
                if (cdb_valid[l]) begin
                    seen_cnt[cdb_tag[l]] = seen_cnt[cdb_tag[l]] + 1;
                    seen_val[cdb_tag[l]] = cdb_value[l];
                    seen_cyc[cdb_tag[l]] = cyc_cnt;
                end
            end
        end
    end

    // ========================================
    // Reference model and checks
    // ========================================
    function automatic logic [31:0] alu_model(input logic [3:0] f, input logic [31:0] a,
                                              input logic [31:0] b, input logic us,
                                              input logic [4:0] sh);
        logic [4:0]  amt;
        logic [31:0] r;
        logic        lt;
        amt = us ? sh : b[4:0];
        // Signed compare from the sign bits first
        lt = (a[31] != b[31]) ? a[31] : (a < b);
        case (f)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_SLL:  r = a << amt;
            ALU_SRL:  r = a >> amt;
            ALU_SRA:  r = (a >> amt) | (a[31] ? ~(32'hffff_ffff >> amt) : 32'h0);
            ALU_SLT:  r = {31'd0, lt};
            ALU_SLTU: r = {31'd0, a < b};
            default:  r = 32'h0;
        endcase
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    function automatic logic ready_of(input int unit);
        case (unit)
            0:       return alu0_ready;
            1:       return alu1_ready;
            default: return lsu_ready;
        endcase
    endfunction

    function automatic logic [9:0] pick_written();
        return written_q[$urandom % written_q.size()];
    endfunction

    // ========================================
    // Drive and wait helpers
    // ========================================
    task automatic present_alu(input int unit, input int tag, input logic [3:0] f,
                               input logic us);
        uop_word_u   op;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        a = $urandom;
        b = $urandom;
        sh = 5'($urandom);
        op = '0;
        op.alu.func = alu_func_e'(f);
        op.alu.use_shamt = us;
        op.alu.shamt = sh;
        exp_val[tag] = alu_model(f, a, b, us, sh);
        if (unit == 0) begin
            alu0_valid   <= 1'b1;
            alu0_op      <= op;
            alu0_dst_tag <= 6'(tag);
            alu0_src1    <= a;
            alu0_src2    <= b;
        end else begin
            alu1_valid   <= 1'b1;
            alu1_op      <= op;
            alu1_dst_tag <= 6'(tag);
            alu1_src1    <= a;
            alu1_src2    <= b;
        end
    endtask

    // Random base and offset that land on word w
    task automatic present_lsu(input logic is_load, input logic [9:0] w,
                               input logic [31:0] data, input int tag, input logic neg);
        uop_word_u   op;
        logic [10:0] off;
        off = 11'(($urandom % 256) * 4);
        if (neg) begin
            off = 11'd0 - off - 11'd4;
        end
        op = '0;
        op.mem.is_load = is_load;
        op.mem.offset = off;
        lsu_valid      <= 1'b1;
        lsu_op         <= op;
        lsu_dst_tag    <= 6'(tag);
        lsu_base       <= ($urandom << 12) + {20'd0, w, 2'b00} - {{21{off[10]}}, off};
        lsu_store_data <= data;
    endtask

    task automatic present_load(input int tag, input logic [9:0] w);
        exp_val[tag] = mem_model[w];
        present_lsu(1'b1, w, 32'h0, tag, 1'($urandom));
    endtask

    task automatic idle_slot(input int unit);
        case (unit)
            0:       alu0_valid <= 1'b0;
            1:       alu1_valid <= 1'b0;
            default: lsu_valid  <= 1'b0;
        endcase
    endtask

    task automatic wait_ready(input int unit);
        int t;
        t = 0;
        @(posedge clk);
        while (!ready_of(unit) && t < 50) begin
            @(posedge clk);
            t++;
        end
        check_true(ready_of(unit), $sformatf("unit %0d stayed busy past the timeout", unit));
    endtask

    task automatic wait_accept(input int unit, output int acc);
        wait_ready(unit);
        acc = cyc_cnt;
    endtask

    task automatic wait_tag(input int tag);
        int t;
        t = 0;
        while (seen_cnt[tag] == start_cnt[tag] && t < 100) begin
            @(posedge clk);
            t++;
        end
        check_true(seen_cnt[tag] != start_cnt[tag],
                   $sformatf("tag %0d never appeared on the CDB", tag));
    endtask

    task automatic read_prf_check(input int tag);
        rd_tag <= 6'(tag);
        @(posedge clk);
        check_value("rd_data", rd_data, exp_val[tag]);
    endtask

    task automatic mark_board();
        for (int t = 0; t < NUM_PHYS; t++) begin
            start_cnt[t] = seen_cnt[t];
        end
    endtask

    // Tags lo..hi-1 exactly once with the model value, all others never
    task automatic check_board(input int lo, input int hi);
        int n;
        for (int t = 0; t < NUM_PHYS; t++) begin
            n = seen_cnt[t] - start_cnt[t];
            if (t >= lo && t < hi) begin
                check_value($sformatf("cdb_tag %0d count", t), n, 1);
                check_value($sformatf("cdb_value of tag %0d", t), seen_val[t], exp_val[t]);
            end else begin
                check_value($sformatf("cdb_tag %0d count", t), n, 0);
            end
        end
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic after_reset();
        int e0;
        e0 = errors;
        @(posedge clk);
        check_value("alu0_ready", 32'(alu0_ready), 1);
        check_value("alu1_ready", 32'(alu1_ready), 1);
        check_value("lsu_ready", 32'(lsu_ready), 1);
        check_value("cdb_valid", 32'(cdb_valid), 0);
        for (int i = 0; i < 8; i++) begin
            rd_tag <= 6'($urandom);
            @(posedge clk);
            check_value("rd_data", rd_data, 0);
        end
        $display("after_reset: %0d errors", errors - e0);
    endtask

    task automatic alu_functions();
        int         e0;
        int         tag;
        int         acc;
        logic [3:0] fn;
        e0 = errors;
        tag = 0;
        mark_board();
        @(posedge clk);
        for (int u = 0; u < 2; u++) begin
            // Steps 10 to 12 repeat the shifts with shamt
            for (int s = 0; s < 13; s++) begin
                fn = 4'((s < 10) ? s : s - 5);
                present_alu(u, tag, fn, s >= 10);
                wait_accept(u, acc);
                idle_slot(u);
                wait_tag(tag);
                check_value("cdb_value", seen_val[tag], exp_val[tag]);
                check_value("cdb_valid cycle", seen_cyc[tag], acc + 2);
                read_prf_check(tag);
                tag++;
            end
        end
        check_board(0, tag);
        $display("alu_functions: %0d errors", errors - e0);
    endtask

    task automatic store_then_load();
        int          e0;
        int          acc;
        logic [9:0]  w;
        logic [31:0] d;
        e0 = errors;
        mark_board();
        @(posedge clk);
        for (int i = 0; i < 8; i++) begin
            w = 10'($urandom);
            d = $urandom;
            present_lsu(1'b0, w, d, 63, i % 2 == 1);
            wait_accept(2, acc);
            idle_slot(2);
            wait_ready(2);
            mem_model[w] = d;
            written_q.push_back(w);
        end
        foreach (written_q[i]) begin
            present_load(i, written_q[i]);
            wait_accept(2, acc);
            idle_slot(2);
            wait_tag(i);
            read_prf_check(i);
        end
        // Store tag 63 must never reach the CDB
        check_board(0, written_q.size());
        $display("store_then_load: %0d errors", errors - e0);
    endtask

    task automatic three_way_issue();
        int e0;
        e0 = errors;
        mark_board();
        @(posedge clk);
        for (int r = 0; r < 4; r++) begin
            present_alu(0, 3 * r, 4'($urandom % 10), 1'($urandom));
            present_alu(1, 3 * r + 1, 4'($urandom % 10), 1'($urandom));
            present_load(3 * r + 2, pick_written());
            @(posedge clk);
            check_true(alu0_ready && alu1_ready && lsu_ready,
                       "the three units were not ready together for the joint issue");
            idle_slot(0);
            idle_slot(1);
            idle_slot(2);
            for (int k = 0; k < 3; k++) begin
                wait_tag(3 * r + k);
            end
            wait_ready(2);
        end
        repeat (4) @(posedge clk);
        check_board(0, 12);
        $display("three_way_issue: %0d errors", errors - e0);
    endtask

    task automatic back_pressure();
        int e0;
        int n0;
        int n1;
        int nl;
        int t;
        e0 = errors;
        for (int r = 0; r < 2; r++) begin
            mark_board();
            n0 = 0;
            n1 = 0;
            nl = 0;
            t = 0;
            @(posedge clk);
            present_alu(0, 0, 4'($urandom % 10), 1'($urandom));
            present_alu(1, 20, 4'($urandom % 10), 1'($urandom));
            present_load(40, pick_written());
            // Tags 0-19 alu0, 20-39 alu1, 40-47 lsu loads
            while ((n0 < 20 || n1 < 20 || nl < 8) && t < 400) begin
                @(posedge clk);
                t++;
                if (alu0_valid && alu0_ready) begin
                    n0++;
                    if (n0 < 20) present_alu(0, n0, 4'($urandom % 10), 1'($urandom));
                    else idle_slot(0);
                end
                if (alu1_valid && alu1_ready) begin
                    n1++;
                    if (n1 < 20) present_alu(1, 20 + n1, 4'($urandom % 10), 1'($urandom));
                    else idle_slot(1);
                end
                if (lsu_valid && lsu_ready) begin
                    nl++;
                    if (nl < 8) present_load(40 + nl, pick_written());
                    else idle_slot(2);
                end
            end
            check_true(t < 400, "issue loop under back-pressure did not finish in time");
            for (int k = 0; k < 48; k++) begin
                wait_tag(k);
            end
            wait_ready(2);
            repeat (4) @(posedge clk);
            check_board(0, 48);
        end
        $display("back_pressure: %0d errors", errors - e0);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        void'($urandom(32'h5e79_f814));
        errors = 0;
        checks = 0;
        rst_n = 1'b0;
        alu0_valid = 1'b0;
        alu0_op = '0;
        alu0_dst_tag = '0;
        alu0_src1 = '0;
        alu0_src2 = '0;
        alu1_valid = 1'b0;
        alu1_op = '0;
        alu1_dst_tag = '0;
        alu1_src1 = '0;
        alu1_src2 = '0;
        lsu_valid = 1'b0;
        lsu_op = '0;
        lsu_dst_tag = '0;
        lsu_base = '0;
        lsu_store_data = '0;
        rd_tag = '0;
        for (int t = 0; t < NUM_PHYS; t++) begin
            start_cnt[t] = 0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        after_reset();
        alu_functions();
        store_then_load();
        three_way_issue();
        back_pressure();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: tests/exec_cluster_assert.sv
`timescale 1ns/1ns

module exec_cluster_assert import core_cfg_pkg::*; (
    input logic                             clk,
    input logic                             rst_n,
    input logic [NUM_PROD-1:0]              req,
    input logic [NUM_PROD-1:0][PTAG_W-1:0]  req_tag,
    input logic [NUM_PROD-1:0][XLEN-1:0]    req_value,
    input logic [NUM_PROD-1:0]              gnt,
    input logic [CDB_LANES-1:0]             cdb_valid,
    input logic [CDB_LANES-1:0][PTAG_W-1:0] cdb_tag
);

    gnt_only_to_req: assert property (@(posedge clk) disable iff (!rst_n)
        (gnt & ~req) == '0)
        else $error("grant given to a producer that is not requesting");

    two_gnt_max: assert property (@(posedge clk) disable iff (!rst_n)
        $countones(gnt) <= CDB_LANES)
        else $error("more grants than CDB lanes in one cycle");

    lanes_distinct: assert property (@(posedge clk) disable iff (!rst_n)
        &cdb_valid |-> cdb_tag[0] != cdb_tag[1])
        else $error("both CDB lanes carry the same tag");

    // A denied request holds until granted
    for (genvar p = 0; p < NUM_PROD; p++) begin : g_hold
        denied_req_holds: assert property (@(posedge clk) disable iff (!rst_n)
            req[p] && !gnt[p] |=> req[p] && $stable(req_tag[p]) && $stable(req_value[p]))
            else $error("producer %0d dropped or changed a denied request", p);
    end

endmodule

bind cdb_arbiter exec_cluster_assert i_exec_cluster_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .req_tag  (req_tag),
    .req_value(req_value),
    .gnt      (gnt),
    .cdb_valid(cdb_valid),
    .cdb_tag  (cdb_tag)
);

// File: hdl/exec_cluster.sv
`timescale 1ns/1ns

module exec_cluster import core_cfg_pkg::*, uop_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n,
    // ALU0 issue slot
    input  logic                             alu0_valid,
    output logic                             alu0_ready,
    input  uop_word_u                        alu0_op,
    input  logic [PTAG_W-1:0]                alu0_dst_tag,
    input  logic [XLEN-1:0]                  alu0_src1,
    input  logic [XLEN-1:0]                  alu0_src2,
    // ALU1 issue slot
    input  logic                             alu1_valid,
    output logic                             alu1_ready,
    input  uop_word_u                        alu1_op,
    input  logic [PTAG_W-1:0]                alu1_dst_tag,
    input  logic [XLEN-1:0]                  alu1_src1,
    input  logic [XLEN-1:0]                  alu1_src2,
    // LSU issue slot
    input  logic                             lsu_valid,
    output logic                             lsu_ready,
    input  uop_word_u                        lsu_op,
    input  logic [PTAG_W-1:0]                lsu_dst_tag,
    input  logic [XLEN-1:0]                  lsu_base,
    input  logic [XLEN-1:0]                  lsu_store_data,
    // CDB
    output logic [CDB_LANES-1:0]             cdb_valid,
    output logic [CDB_LANES-1:0][PTAG_W-1:0] cdb_tag,
    output logic [CDB_LANES-1:0][XLEN-1:0]   cdb_value,
    // PRF read port
    input  logic [PTAG_W-1:0]                rd_tag,
    output logic [XLEN-1:0]                  rd_data
);

    // ========================================
    // Producers: 0 alu0, 1 alu1, 2 lsu
    // ========================================
    logic [NUM_PROD-1:0]             prod_req;
    logic [NUM_PROD-1:0]             prod_gnt;
    logic [NUM_PROD-1:0][PTAG_W-1:0] prod_tag;
    logic [NUM_PROD-1:0][XLEN-1:0]   prod_value;

    // Wishbone, LSU to scratchpad
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [DMEM_AW-1:0] wb_adr;
    logic [XLEN-1:0]    wb_dat_w;
    logic [XLEN-1:0]    wb_dat_r;
    logic               wb_ack;

    alu i_alu0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (alu0_valid),
        .issue_ready  (alu0_ready),
        .issue_op     (alu0_op),
        .issue_dst_tag(alu0_dst_tag),
        .src1         (alu0_src1),
        .src2         (alu0_src2),
        .req          (prod_req[0]),
        .gnt          (prod_gnt[0]),
        .req_tag      (prod_tag[0]),
        .req_value    (prod_value[0])
    );

    alu i_alu1 (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (alu1_valid),
        .issue_ready  (alu1_ready),
        .issue_op     (alu1_op),
        .issue_dst_tag(alu1_dst_tag),
        .src1         (alu1_src1),
        .src2         (alu1_src2),
        .req          (prod_req[1]),
        .gnt          (prod_gnt[1]),
        .req_tag      (prod_tag[1]),
        .req_value    (prod_value[1])
    );

    lsu i_lsu (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (lsu_valid),
        .issue_ready  (lsu_ready),
        .issue_op     (lsu_op),
        .issue_dst_tag(lsu_dst_tag),
        .base         (lsu_base),
        .store_data   (lsu_store_data),
        .cyc          (wb_cyc),
        .stb          (wb_stb),
        .we           (wb_we),
        .adr          (wb_adr),
        .dat_w        (wb_dat_w),
        .dat_r        (wb_dat_r),
        .ack          (wb_ack),
        .req          (prod_req[2]),
        .gnt          (prod_gnt[2]),
        .req_tag      (prod_tag[2]),
        .req_value    (prod_value[2])
    );

    data_scratchpad i_data_scratchpad (
        .clk  (clk),
        .rst_n(rst_n),
        .cyc  (wb_cyc),
        .stb  (wb_stb),
        .we   (wb_we),
        .adr  (wb_adr),
        .dat_w(wb_dat_w),
        .dat_r(wb_dat_r),
        .ack  (wb_ack)
    );

    // ========================================
    // CDB and PRF
    // ========================================
    cdb_arbiter i_cdb_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (prod_req),
        .req_tag  (prod_tag),
        .req_value(prod_value),
        .gnt      (prod_gnt),
        .cdb_valid(cdb_valid),
        .cdb_tag  (cdb_tag),
        .cdb_value(cdb_value)
    );

    phys_regfile i_phys_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .cdb_valid(cdb_valid),
        .cdb_tag  (cdb_tag),
        .cdb_value(cdb_value),
        .rd_tag   (rd_tag),
        .rd_data  (rd_data)
    );

endmodule

// File: hdl/phys_regfile.sv
`timescale 1ns/1ns

module phys_regfile import core_cfg_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [CDB_LANES-1:0]             cdb_valid,
    input  logic [CDB_LANES-1:0][PTAG_W-1:0] cdb_tag,
    input  logic [CDB_LANES-1:0][XLEN-1:0]   cdb_value,
    input  logic [PTAG_W-1:0]                rd_tag,
    output logic [XLEN-1:0]                  rd_data
);

    logic [NUM_PHYS-1:0][XLEN-1:0] regs;

    // One write port per CDB lane
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '0;
        end else begin
            for (int l = 0; l < CDB_LANES; l++) begin
                if (cdb_valid[l]) begin
                    regs[cdb_tag[l]] <= cdb_value[l];
                end
            end
        end
    end

    // Dispatch-side read, no bypass
    assign rd_data = regs[rd_tag];

endmodule

// File: hdl/cdb_arbiter.sv
`timescale 1ns/1ns

module cdb_arbiter import core_cfg_pkg::*; (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [NUM_PROD-1:0]                req,
    input  logic [NUM_PROD-1:0][PTAG_W-1:0]    req_tag,
    input  logic [NUM_PROD-1:0][XLEN-1:0]      req_value,
    output logic [NUM_PROD-1:0]                gnt,
    output logic [CDB_LANES-1:0]               cdb_valid,
    output logic [CDB_LANES-1:0][PTAG_W-1:0]   cdb_tag,
    output logic [CDB_LANES-1:0][XLEN-1:0]     cdb_value
);

    // Producer first in line
    logic [$clog2(NUM_PROD)-1:0]                ptr;
    logic [CDB_LANES-1:0]                       pick_vld;
    logic [CDB_LANES-1:0][$clog2(NUM_PROD)-1:0] pick_idx;
    logic                                       deny_vld;
    logic [$clog2(NUM_PROD)-1:0]                deny_idx;

    // ========================================
    // Pick first requesters from ptr onward
    // ========================================
    always_comb begin
        int unsigned cnt;
        int unsigned idx;
        cnt      = 0;
        gnt      = '0;
        pick_vld = '0;
        pick_idx = '0;
        deny_vld = 1'b0;
        deny_idx = ptr;
        for (int i = 0; i < NUM_PROD; i++) begin
            idx = ptr + i;
            if (idx >= NUM_PROD) begin
                idx = idx - NUM_PROD;
            end
            if (req[idx]) begin
                if (cnt < CDB_LANES) begin
                    gnt[idx]      = 1'b1;
                    pick_vld[cnt] = 1'b1;
                    pick_idx[cnt] = idx[$clog2(NUM_PROD)-1:0];
                    cnt++;
                end else begin
                    deny_vld = 1'b1;
                    deny_idx = idx[$clog2(NUM_PROD)-1:0];
                end
            end
        end
    end

    // Denied producer goes first next time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr       <= '0;
            cdb_valid <= '0;
        end else begin
            cdb_valid <= pick_vld;
            if (deny_vld) begin
                ptr <= deny_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < CDB_LANES; l++) begin
            cdb_tag[l]   <= req_tag[pick_idx[l]];
            cdb_value[l] <= req_value[pick_idx[l]];
        end
    end

endmodule

// File: hdl/data_scratchpad.sv
`timescale 1ns/1ns

module data_scratchpad import core_cfg_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  logic [DMEM_AW-1:0] adr,
    input  logic [XLEN-1:0]    dat_w,
    output logic [XLEN-1:0]    dat_r,
    output logic               ack
);

    logic [XLEN-1:0] mem [DMEM_WORDS];
    logic            access;

    // New strobe, not the cycle that is being acked
    assign access = cyc && stb && !ack;

    // Single-cycle ack, one cycle after strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (we) begin
                mem[adr] <= dat_w;
            end
            dat_r <= mem[adr];
        end
    end

endmodule

// File: hdl/lsu.sv
`timescale 1ns/1ns

module lsu import core_cfg_pkg::*, uop_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_valid,
    output logic               issue_ready,
    input  uop_word_u          issue_op,
    input  logic [PTAG_W-1:0]  issue_dst_tag,
    input  logic [XLEN-1:0]    base,
    input  logic [XLEN-1:0]    store_data,
    // Wishbone master
    output logic               cyc,
    output logic               stb,
    output logic               we,
    output logic [DMEM_AW-1:0] adr,
    output logic [XLEN-1:0]    dat_w,
    input  logic [XLEN-1:0]    dat_r,
    input  logic               ack,
    // CDB request
    output logic               req,
    input  logic               gnt,
    output logic [PTAG_W-1:0]  req_tag,
    output logic [XLEN-1:0]    req_value
);

    enum logic [1:0] {S_IDLE, S_BUS, S_RESULT} state;

    logic [XLEN-1:0] eff_addr;
    logic            accept;

    // Byte address from base and sign-extended offset
    assign eff_addr = base + {{(XLEN - 11){issue_op.mem.offset[10]}}, issue_op.mem.offset};

    assign issue_ready = (state == S_IDLE);
    assign accept      = issue_valid && issue_ready;

    assign cyc = (state == S_BUS);
    assign stb = (state == S_BUS);
    assign req = (state == S_RESULT);

    // ========================================
    // Sequencer
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            we    <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state <= S_BUS;
                        we    <= !issue_op.mem.is_load;
                    end
                end
                // Stores finish on ack, loads go on to the CDB
                S_BUS: begin
                    if (ack) begin
                        state <= we ? S_IDLE : S_RESULT;
                    end
                end
                S_RESULT: begin
                    if (gnt) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Bus payload and load result
    always_ff @(posedge clk) begin
        if (accept) begin
            adr     <= eff_addr[DMEM_AW+1:2];
            dat_w   <= store_data;
            req_tag <= issue_dst_tag;
        end
        if (state == S_BUS && ack && !we) begin
            req_value <= dat_r;
        end
    end

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ns

module alu import core_cfg_pkg::*, uop_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue_valid,
    output logic              issue_ready,
    input  uop_word_u         issue_op,
    input  logic [PTAG_W-1:0] issue_dst_tag,
    input  logic [XLEN-1:0]   src1,
    input  logic [XLEN-1:0]   src2,
    output logic              req,
    input  logic              gnt,
    output logic [PTAG_W-1:0] req_tag,
    output logic [XLEN-1:0]   req_value
);

    logic [4:0]      shift_amt;
    logic [XLEN-1:0] alu_out;
    logic            accept;

    // Free slot, or the held result leaves this cycle
    assign issue_ready = !req || gnt;
    assign accept      = issue_valid && issue_ready;

    // Immediate shift amount overrides src2
    assign shift_amt = issue_op.alu.use_shamt ? issue_op.alu.shamt : src2[4:0];

    always_comb begin
        case (issue_op.alu.func)
            ALU_ADD:  alu_out = src1 + src2;
            ALU_SUB:  alu_out = src1 - src2;
            ALU_AND:  alu_out = src1 & src2;
            ALU_OR:   alu_out = src1 | src2;
            ALU_XOR:  alu_out = src1 ^ src2;
            ALU_SLL:  alu_out = src1 << shift_amt;
            ALU_SRL:  alu_out = src1 >> shift_amt;
            ALU_SRA:  alu_out = $unsigned($signed(src1) >>> shift_amt);
            ALU_SLT:  alu_out = XLEN'($signed(src1) < $signed(src2));
            ALU_SLTU: alu_out = XLEN'(src1 < src2);
            default:  alu_out = '0;
        endcase
    end

    // ========================================
    // Result register, requests CDB until granted
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req <= 1'b0;
        end else if (accept) begin
            req <= 1'b1;
        end else if (gnt) begin
            req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_tag   <= issue_dst_tag;
            req_value <= alu_out;
        end
    end

endmodule

// File: hdl/uop_pkg.sv
package uop_pkg;

    // ========================================
    // ALU function codes
    // ========================================
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_func_e;

    // ========================================
    // Micro-op word, 12 bits, two views
    // ========================================

    // ALU view
    typedef struct packed {
        alu_func_e  func;
        logic       use_shamt;
        logic [4:0] shamt;
        logic [1:0] rsvd;
    } alu_op_t;

    // Memory view, offset is a signed byte offset
    typedef struct packed {
        logic              is_load;
        logic signed [10:0] offset;
    } mem_op_t;

    typedef union packed {
        alu_op_t alu;
        mem_op_t mem;
    } uop_word_u;

endpackage

// File: hdl/core_cfg_pkg.sv
package core_cfg_pkg;

    // ========================================
    // Data path
    // ========================================
    localparam int XLEN = 32;

    // Physical tags and PRF depth
    localparam int PTAG_W   = 6;
    localparam int NUM_PHYS = 64;

    // ========================================
    // Data scratchpad
    // ========================================
    localparam int DMEM_WORDS = 1024;
    // Word index, byte address bits 11:2
    localparam int DMEM_AW    = 10;

    // ========================================
    // Common data bus
    // ========================================
    localparam int CDB_LANES = 2;
    // alu0, alu1, lsu
    localparam int NUM_PROD  = 3;

endpackage
